// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_soc_board
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  soc_pkg::bus_req_t   bus,
    output logic [10:0]         mem_rd_index,
    input  logic [31:0]         mem_rd_word,
    output soc_pkg::mem_wr_t    mem_wr,
    input  soc_pkg::key_event_t key_event,
    output logic [7:0]          key_code,
    output logic [63:0]         rdata,
    output logic                console_valid,
    output logic [7:0]          console_data
);
    import soc_pkg::*;

    region_e     region;
    region_e     rd_region_q;
    logic        re_q;
    logic [63:0] read_mux;
    logic [63:0] held_q;

    // offset compare keeps the zero-based rom check well formed
    function automatic region_e decode_region(input logic [63:0] addr);
        if ((addr - rom_base) < rom_size) begin
            return region_rom;
        end
        if ((addr - ram_base) < ram_size) begin
            return region_ram;
        end
        if (addr == console_addr) begin
            return region_console;
        end
        if (addr == key_addr) begin
            return region_key;
        end
        return region_none;
    endfunction

    assign region = decode_region(bus.addr);

    // word index, memory registers it on the same edge as re
    assign mem_rd_index = bus.addr[12:2];

    // only ram takes writes, low half of the bus word
    assign mem_wr.index = bus.addr[12:2];
    assign mem_wr.data  = bus.wdata[31:0];
    assign mem_wr.en    = bus.we && (region == region_ram);

    // remember what the read was aimed at
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            re_q        <= 1'b0;
            rd_region_q <= region_none;
        end else begin
            re_q <= bus.re;
            if (bus.re) begin
                rd_region_q <= region;
            end
        end
    end

    // pick the source one cycle after re
    always_comb begin
        case (rd_region_q)
            region_rom,
            region_ram: read_mux = {32'd0, mem_rd_word};
            region_key: read_mux = {56'd0, key_code};
            default:    read_mux = unmapped_data;
        endcase
    end

    // keeps rdata steady between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q <= '0;
        end else if (re_q) begin
            held_q <= read_mux;
        end
    end

    // fresh value straight through, otherwise the held one
    assign rdata = re_q ? read_mux : held_q;

    // last pressed key, releases leave it alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_code <= 8'd0;
        end else if (key_event.valid && !key_event.released) begin
            key_code <= key_event.scan;
        end
    end

    // console strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            console_valid <= 1'b0;
        end else begin
            console_valid <= bus.we && (region == region_console);
        end
    end

    // console byte
    always_ff @(posedge clk) begin
        if (bus.we && (region == region_console)) begin
            console_data <= bus.wdata[7:0];
        end
    end

    // core never reads and writes in the same cycle
    assert property (@(posedge clk) disable iff (!rst_n) !(bus.re && bus.we));

    // memory writes only ever come from the ram window
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr.en |-> (bus.addr >= ram_base && bus.addr < ram_base + ram_size));

endmodule

// ==== hdl/irq_controller.sv ====
`timescale 1ns/1ps

module irq_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  soc_pkg::key_event_t key_event,
    input  logic                irq_ack,
    output logic [3:0]          irq_vector,
    output logic                irq_led
);
    import soc_pkg::*;

    logic key_press;
    logic ack_hit;

    // zero scan code would look like no key at all
    assign key_press = key_event.valid && !key_event.released && (key_event.scan != 8'd0);

    // ack only counts while something is pending
    assign ack_hit = irq_ack && (irq_vector != 4'd0);

    // level held until the core acks, ack beats a new press
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_vector <= 4'd0;
            irq_led    <= 1'b0;
        end else if (ack_hit) begin
            irq_vector <= 4'd0;
            irq_led    <= 1'b0;
        end else if (key_press) begin
            irq_vector <= key_irq_vector;
            irq_led    <= 1'b1;
        end
    end

    // pending interrupt stays up with its led until the core acks
    assert property (@(posedge clk) disable iff (!rst_n)
        (irq_vector != 4'd0 && !irq_ack) |=> (irq_led && irq_vector == $past(irq_vector)));

endmodule

// ==== hdl/ps2_receiver.sv ====
`timescale 1ns/1ps

module ps2_receiver (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output soc_pkg::key_event_t key_event
);
    import soc_pkg::*;

    logic        clk_s1;
    logic        clk_s2;
    logic        clk_d;
    logic        dat_s1;
    logic        dat_s2;
    logic        clk_fall;
    logic [3:0]  bit_cnt;
    logic [10:0] shift_q;
    logic        frame_ready;
    logic        release_pending;
    logic [7:0]  frame_code;
    logic        frame_good;

    // two-flop sync on both lines, third flop for the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_s1 <= 1'b1;
            clk_s2 <= 1'b1;
            clk_d  <= 1'b1;
            dat_s1 <= 1'b1;
            dat_s2 <= 1'b1;
        end else begin
            clk_s1 <= ps2_clk;
            clk_s2 <= clk_s1;
            clk_d  <= clk_s2;
            dat_s1 <= ps2_dat;
            dat_s2 <= dat_s1;
        end
    end

    // device changes data on rising, we sample on falling
    assign clk_fall = clk_d && !clk_s2;

    // lsb first, start bit ends up in bit 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt     <= 4'd0;
            shift_q     <= '0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= 1'b0;
            if (clk_fall) begin
                shift_q <= {dat_s2, shift_q[10:1]};
                if (bit_cnt == 4'd10) begin
                    bit_cnt     <= 4'd0;
                    frame_ready <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // start low, stop high, odd parity over data plus parity bit
    assign frame_code = shift_q[8:1];
    assign frame_good = !shift_q[0] && shift_q[10] && (^shift_q[9:1]);

    // F0 prefix turns the next code into a release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_event       <= '0;
            release_pending <= 1'b0;
        end else begin
            key_event.valid <= 1'b0;
            if (frame_ready) begin
                if (!frame_good) begin
                    // broken frame, drop it and any prefix
                    release_pending <= 1'b0;
                end else if (frame_code == ps2_release_code) begin
                    release_pending <= 1'b1;
                end else begin
                    key_event.valid    <= 1'b1;
                    key_event.released <= release_pending;
                    key_event.scan     <= frame_code;
                    release_pending    <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hdl/soc_board.sv ====
`timescale 1ns/1ps

module soc_board (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              PS2_CLK,
    input  logic              PS2_DAT,
    input  logic [63:0]       fetch_addr,
    output logic [31:0]       fetch_word,
    input  soc_pkg::bus_req_t bus,
    output logic [63:0]       rdata,
    output logic [3:0]        irq_vector,
    input  logic              irq_ack,
    output logic              console_valid,
    output logic [7:0]        console_data,
    output logic [7:0]        LEDG,
    output logic              LEDR7
);
    import soc_pkg::*;

    logic [10:0] mem_rd_index;
    logic [31:0] mem_rd_word;
    mem_wr_t     mem_wr;
    key_event_t  key_event;

    // address decode, console strobe and key register
    // green leds show the last pressed code
    bus_decoder bus_decoder_i (
        .clk           (CLOCK_50),
        .rst_n         (KEY0),
        .bus           (bus),
        .mem_rd_index  (mem_rd_index),
        .mem_rd_word   (mem_rd_word),
        .mem_wr        (mem_wr),
        .key_event     (key_event),
        .key_code      (LEDG),
        .rdata         (rdata),
        .console_valid (console_valid),
        .console_data  (console_data)
    );

    // shared word memory, fetch and data ports
    unified_memory unified_memory_i (
        .clk        (CLOCK_50),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word),
        .rd_index   (mem_rd_index),
        .rd_word    (mem_rd_word),
        .wr         (mem_wr)
    );

    // keyboard frames to press and release events
    ps2_receiver ps2_receiver_i (
        .clk       (CLOCK_50),
        .rst_n     (KEY0),
        .ps2_clk   (PS2_CLK),
        .ps2_dat   (PS2_DAT),
        .key_event (key_event)
    );

    // red led 7 lights while the interrupt is pending
    irq_controller irq_controller_i (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .key_event  (key_event),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector),
        .irq_led    (LEDR7)
    );

endmodule

// ==== hdl/soc_pkg.sv ====
package soc_pkg;

    // memory map, fixed by the board
    // read-only boot region, memory words 0 to 1023
    localparam logic [63:0] rom_base = 64'h0000_0000_0000_0000;
    localparam logic [63:0] rom_size = 64'h0000_0000_0000_1000;

    // writable region, memory words 1024 to 2047
    localparam logic [63:0] ram_base = 64'h0000_0000_0000_1000;
    localparam logic [63:0] ram_size = 64'h0000_0000_0000_1000;

    // single-address peripherals
    localparam logic [63:0] console_addr = 64'h0000_0000_0000_FFFF;
    localparam logic [63:0] key_addr     = 64'h0000_0000_0000_FFFE;

    // returned for anything not decoded
    localparam logic [63:0] unmapped_data = 64'hDEAD_BEEF_DEAD_BEEF;

    // one shared array covers rom and ram
    localparam int mem_words = 2048;

    // first word index that may be written
    localparam logic [10:0] ram_first_word = 11'(ram_base >> 2);

    // set 2 prefix byte sent ahead of a key release
    localparam logic [7:0] ps2_release_code = 8'hF0;

    // vector the core sees for a keyboard interrupt
    localparam logic [3:0] key_irq_vector = 4'd1;

    // data request from the core
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic        we;
        logic        re;
    } bus_req_t;

    // one write into the shared memory
    typedef struct packed {
        logic [10:0] index;
        logic [31:0] data;
        logic        en;
    } mem_wr_t;

    // press or release of one key, valid for a single cycle
    typedef struct packed {
        logic       valid;
        logic       released;
        logic [7:0] scan;
    } key_event_t;

    // what a bus address points at
    typedef enum logic [2:0] {
        region_rom,
        region_ram,
        region_console,
        region_key,
        region_none
    } region_e;

endpackage

// ==== hdl/unified_memory.sv ====
`timescale 1ns/1ps

module unified_memory (
    input  logic             clk,
    input  logic [63:0]      fetch_addr,
    output logic [31:0]      fetch_word,
    input  logic [10:0]      rd_index,
    output logic [31:0]      rd_word,
    input  soc_pkg::mem_wr_t wr
);
    import soc_pkg::*;

    // rom in the lower half, ram in the upper half
    logic [31:0] mem [mem_words];
    logic [31:0] fetch_q;

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.index] <= wr.data;
        end
    end

    // instruction port, byte address to word index
    always_ff @(posedge clk) begin
        fetch_q <= mem[fetch_addr[12:2]];
    end

    // data port for the bus decoder
    always_ff @(posedge clk) begin
        rd_word <= mem[rd_index];
    end

    // core expects the opposite byte order on fetch
    assign fetch_word = {fetch_q[7:0], fetch_q[15:8], fetch_q[23:16], fetch_q[31:24]};

    // the decoder must never let a write reach rom words
    assert property (@(posedge clk) wr.en |-> (wr.index >= ram_first_word));

endmodule

// ==== tb.f ====
hdl/soc_pkg.sv
hdl/bus_decoder.sv
hdl/unified_memory.sv
hdl/ps2_receiver.sv
hdl/irq_controller.sv
hdl/soc_board.sv
tests/tb_soc_board.sv

// ==== tests/tb_soc_board.sv ====
`timescale 1ns/1ps

module tb_soc_board;
    import soc_pkg::*;

    // kinds of table rows
    localparam logic [1:0] op_write     = 2'd0;
    localparam logic [1:0] op_read      = 2'd1;
    localparam logic [1:0] op_read_keep = 2'd2;
    localparam logic [1:0] op_read_same = 2'd3;

    // one bus operation with its expected read value
    typedef struct packed {
        logic [1:0]  kind;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [63:0] expected;
    } bus_op_t;

    logic        CLOCK_50;
    logic        KEY0;
    logic        PS2_CLK;
    logic        PS2_DAT;
    logic [63:0] fetch_addr;
    logic [31:0] fetch_word;
    bus_req_t    bus;
    logic [63:0] rdata;
    logic [3:0]  irq_vector;
    logic        irq_ack;
    logic        console_valid;
    logic [7:0]  console_data;
    logic [7:0]  LEDG;
    logic        LEDR7;

    bus_op_t     ops[$];
    logic [31:0] lcg_state;
    logic [63:0] ram_addr[4];
    logic [63:0] ram_data[4];
    logic [63:0] kept;
    logic [63:0] got;

    soc_board soc_board_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .PS2_CLK       (PS2_CLK),
        .PS2_DAT       (PS2_DAT),
        .fetch_addr    (fetch_addr),
        .fetch_word    (fetch_word),
        .bus           (bus),
        .rdata         (rdata),
        .irq_vector    (irq_vector),
        .irq_ack       (irq_ack),
        .console_valid (console_valid),
        .console_data  (console_data),
        .LEDG          (LEDG),
        .LEDR7         (LEDR7)
    );

    // 8 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s got %h expected %h", name, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // 32-bit lcg, classic constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // byte 0 goes to the top
    function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    task automatic add_op(input logic [1:0] kind, input logic [63:0] addr,
                          input logic [63:0] wdata, input logic [63:0] expected);
        bus_op_t op;
        op.kind     = kind;
        op.addr     = addr;
        op.wdata    = wdata;
        op.expected = expected;
        ops.push_back(op);
    endtask

    // tasks start and end on a falling edge
    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        bus.addr  = addr;
        bus.wdata = data;
        bus.we    = 1'b1;
        @(negedge CLOCK_50);
        bus.we = 1'b0;
    endtask

    // data one cycle after re, then must hold while idle
    task automatic bus_read(input logic [63:0] addr, output logic [63:0] data);
        bus.addr = addr;
        bus.re   = 1'b1;
        @(negedge CLOCK_50);
        bus.re   = 1'b0;
        // point elsewhere so a missing hold shows up
        bus.addr = ~addr;
        data     = rdata;
        @(negedge CLOCK_50);
        check_value("rdata held", rdata, data);
    endtask

    task automatic build_table();
        for (int i = 0; i < 4; i++) begin
            // last one lands on the top ram word
            ram_addr[i] = ram_base + 64'(i) * 64'h554;
            ram_data[i] = {lcg_next(), lcg_next()};
            add_op(op_write, ram_addr[i], ram_data[i], 64'd0);
        end
        // same low bits as ram word 0 but upper bits set
        add_op(op_write, 64'h0000_0001_0000_1000, {lcg_next(), lcg_next()}, 64'd0);
        for (int i = 0; i < 4; i++) begin
            add_op(op_read, ram_addr[i], 64'd0, {32'd0, ram_data[i][31:0]});
        end
        // rom content unknown, only stability matters
        add_op(op_read_keep, rom_base + 64'h40, 64'd0, 64'd0);
        add_op(op_write, rom_base + 64'h40, {lcg_next(), lcg_next()}, 64'd0);
        add_op(op_read_same, rom_base + 64'h40, 64'd0, 64'd0);
        // key register is read only, still 0
        add_op(op_write, key_addr, {lcg_next(), lcg_next()}, 64'd0);
        add_op(op_read, key_addr, 64'd0, 64'd0);
        add_op(op_read, 64'h0000_0000_0000_2000, 64'd0, unmapped_data);
        add_op(op_read, 64'h0000_0001_0000_1000, 64'd0, unmapped_data);
        add_op(op_read, console_addr, 64'd0, unmapped_data);
    endtask

    task automatic apply_op(input bus_op_t op);
        case (op.kind)
            op_write:     bus_write(op.addr, op.wdata);
            op_read_keep: bus_read(op.addr, kept);
            op_read_same: begin
                bus_read(op.addr, got);
                check_value("rdata", got, kept);
            end
            default: begin
                bus_read(op.addr, got);
                check_value("rdata", got, op.expected);
            end
        endcase
    endtask

    // start, 8 data lsb first, parity, stop; data moves while clock is high
    task automatic ps2_send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = frame[i];
            repeat (10) @(negedge CLOCK_50);
            PS2_CLK = 1'b0;
            repeat (10) @(negedge CLOCK_50);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (irq_vector == 4'd0 && n < 400) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (irq_vector == 4'd0) begin
            fail_run("keyboard interrupt never came after a press frame");
        end
    endtask

    // ack clears on the next edge, key code stays
    task automatic ack_irq();
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        check_value("irq_vector", 64'(irq_vector), 64'd0);
        check_value("LEDR7", 64'(LEDR7), 64'd0);
    endtask

    // last-resort limit on the whole run
    initial begin
        repeat (100000) @(posedge CLOCK_50);
        fail_run("simulation ran past its cycle limit");
    end

    initial begin
        KEY0       = 1'b0;
        PS2_CLK    = 1'b1;
        PS2_DAT    = 1'b1;
        fetch_addr = '0;
        bus        = '0;
        irq_ack    = 1'b0;
        lcg_state  = 32'd99;
        repeat (8) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);

        check_value("rdata", rdata, 64'd0);
        check_value("irq_vector", 64'(irq_vector), 64'd0);
        check_value("console_valid", 64'(console_valid), 64'd0);
        check_value("LEDR7", 64'(LEDR7), 64'd0);
        check_value("LEDG", 64'(LEDG), 64'd0);

        build_table();
        foreach (ops[i]) begin
            apply_op(ops[i]);
        end

        // fetch port sees the same words, byte reversed
        for (int i = 0; i < 4; i++) begin
            fetch_addr = ram_addr[i];
            @(negedge CLOCK_50);
            check_value("fetch_word", 64'(fetch_word), 64'(reverse_bytes(ram_data[i][31:0])));
        end

        // console strobe, one cycle only
        bus_write(console_addr, 64'h1234_5678_9ABC_DE5A);
        check_value("console_valid", 64'(console_valid), 64'd1);
        check_value("console_data", 64'(console_data), 64'h5A);
        repeat (4) begin
            @(negedge CLOCK_50);
            if (console_valid) begin
                fail_run("console_valid stayed high for more than one cycle");
            end
        end

        // press of 1C, held until ack
        ps2_send_frame(8'h1C, 1'b0);
        wait_irq();
        check_value("irq_vector", 64'(irq_vector), 64'd1);
        check_value("LEDR7", 64'(LEDR7), 64'd1);
        check_value("LEDG", 64'(LEDG), 64'h1C);
        bus_read(key_addr, got);
        check_value("rdata key", got, 64'h1C);
        repeat (5) @(negedge CLOCK_50);
        check_value("irq_vector", 64'(irq_vector), 64'd1);
        ack_irq();

        // broken parity, then a release sequence
        ps2_send_frame(8'h32, 1'b1);
        repeat (20) @(negedge CLOCK_50);
        check_value("LEDG", 64'(LEDG), 64'h1C);
        check_value("irq_vector", 64'(irq_vector), 64'd0);
        ps2_send_frame(ps2_release_code, 1'b0);
        ps2_send_frame(8'h1B, 1'b0);
        repeat (20) @(negedge CLOCK_50);
        check_value("LEDG", 64'(LEDG), 64'h1C);
        check_value("irq_vector", 64'(irq_vector), 64'd0);
        bus_read(key_addr, got);
        check_value("rdata key", got, 64'h1C);

        // receiver still takes a normal press afterwards
        ps2_send_frame(8'h23, 1'b0);
        wait_irq();
        check_value("LEDG", 64'(LEDG), 64'h23);
        ack_irq();

        $display("Everything OK");
        $finish;
    end

endmodule
